// File: rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int XLEN = 32;

    // data path and address width
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regAddr_t;
    typedef logic [3:0]      byteMask_t;

    // first fetch address
    localparam word_t RESET_PC = '0;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOp_t;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } accessSize_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10,
        WB_IMM = 2'b11
    } wbSel_t;

endpackage

`default_nettype wire

// File: ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import rvPkg::*; ();

    aluOp_t      aluOp;
    logic        aluSrcImm;
    logic        aluSrcPc;
    accessSize_t size;
    logic        loadUnsigned;
    logic        memWrite;
    logic        regWrite;
    wbSel_t      wbSel;
    logic        takeBranch;
    logic        jumpReg;
    logic        except;

    modport decoder (
        output aluOp, aluSrcImm, aluSrcPc, size, loadUnsigned, memWrite,
               regWrite, wbSel, takeBranch, jumpReg, except
    );

    modport datapath (
        input aluOp, aluSrcImm, aluSrcPc, size, loadUnsigned, memWrite,
              regWrite, wbSel, takeBranch, jumpReg, except
    );

    modport lsu (
        input size, loadUnsigned, memWrite
    );

endinterface

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rvPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result,
    output logic   zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = word_t'($signed(a) >>> shamt);
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    assign zero = result == '0;

endmodule

`default_nettype wire

// File: immDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module immDecoder import rvPkg::*; (
    input  word_t instruction,
    output word_t imm
);

    opcode_t opcode;
    logic    sign;

    assign opcode = opcode_t'(instruction[6:0]);
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            OP_STORE: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instruction[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            // r-type and anything unknown
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvPkg::*; (
    input  logic     clk,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  regAddr_t rd,
    input  word_t    writeData,
    input  logic     writeEnable,
    output word_t    rs1Data,
    output word_t    rs2Data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (writeEnable && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    // old value on a same-cycle write
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit import rvPkg::*; (
    ctrlIf.lsu        ctrl,
    input  word_t     addr,
    input  word_t     storeData,
    input  word_t     memOut,
    output word_t     memIn,
    output word_t     loadData,
    output byteMask_t wrMask
);

    logic [1:0] offset;
    logic [4:0] bitShift;
    byteMask_t  sizeMask;
    word_t      loadShifted;
    logic       extBit;

    assign offset   = addr[1:0];
    assign bitShift = {offset, 3'b000};

    always_comb begin
        case (ctrl.size)
            SIZE_BYTE: sizeMask = 4'b0001;
            SIZE_HALF: sizeMask = 4'b0011;
            default:   sizeMask = 4'b1111;
        endcase
    end

    // store side
    assign memIn  = storeData << bitShift;
    assign wrMask = ctrl.memWrite ? byteMask_t'(sizeMask << offset) : 4'b0000;

    // load side, addressed lane moved down to bit 0
    assign loadShifted = memOut >> bitShift;

    always_comb begin
        case (ctrl.size)
            SIZE_BYTE: begin
                extBit   = !ctrl.loadUnsigned && loadShifted[7];
                loadData = {{24{extBit}}, loadShifted[7:0]};
            end
            SIZE_HALF: begin
                extBit   = !ctrl.loadUnsigned && loadShifted[15];
                loadData = {{16{extBit}}, loadShifted[15:0]};
            end
            default: begin
                extBit   = 1'b0;
                loadData = memOut;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller import rvPkg::*; (
    input  word_t  instruction,
    input  logic   aluZero,
    input  word_t  aluResult,
    ctrlIf.decoder ctrl
);

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    aluOp_t      aluOp;
    logic        srcImm;
    logic        srcPc;
    accessSize_t size;
    logic        loadUnsigned;
    logic        memWrite;
    logic        regWrite;
    wbSel_t      wbSel;
    logic        isBranch;
    logic        isJal;
    logic        jumpReg;
    logic        isMem;
    logic        illegal;

    logic        compare;
    logic        branchTaken;
    logic        misaligned;
    logic        except;

    function automatic aluOp_t decodeAluOp(input logic [2:0] f3, input logic alt);
        aluOp_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_t'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // decode only; nothing here looks at the ALU
    always_comb begin
        aluOp        = ALU_PASSB;
        srcImm       = 1'b0;
        srcPc        = 1'b0;
        size         = SIZE_WORD;
        loadUnsigned = 1'b0;
        memWrite     = 1'b0;
        regWrite     = 1'b0;
        wbSel        = WB_ALU;
        isBranch     = 1'b0;
        isJal        = 1'b0;
        jumpReg      = 1'b0;
        isMem        = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            OP_LUI: begin
                regWrite = 1'b1;
                wbSel    = WB_IMM;
            end
            OP_AUIPC: begin
                aluOp    = ALU_ADD;
                srcPc    = 1'b1;
                srcImm   = 1'b1;
                regWrite = 1'b1;
            end
            OP_JAL: begin
                isJal    = 1'b1;
                regWrite = 1'b1;
                wbSel    = WB_PC4;
            end
            OP_JALR: begin
                aluOp    = ALU_ADD;
                srcImm   = 1'b1;
                jumpReg  = 1'b1;
                regWrite = 1'b1;
                wbSel    = WB_PC4;
                illegal  = funct3 != 3'b000;
            end
            OP_BRANCH: begin
                isBranch = 1'b1;
                case (funct3[2:1])
                    2'b00:   aluOp = ALU_SUB;
                    2'b10:   aluOp = ALU_SLT;
                    2'b11:   aluOp = ALU_SLTU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_LOAD: begin
                aluOp        = ALU_ADD;
                srcImm       = 1'b1;
                isMem        = 1'b1;
                regWrite     = 1'b1;
                wbSel        = WB_MEM;
                size         = accessSize_t'(funct3[1:0]);
                loadUnsigned = funct3[2];
                // LWU does not exist in RV32I
                illegal      = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            OP_STORE: begin
                aluOp    = ALU_ADD;
                srcImm   = 1'b1;
                isMem    = 1'b1;
                memWrite = 1'b1;
                size     = accessSize_t'(funct3[1:0]);
                illegal  = funct3[2] || (funct3[1:0] == 2'b11);
            end
            OP_IMM: begin
                srcImm   = 1'b1;
                regWrite = 1'b1;
                aluOp    = decodeAluOp(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    illegal = funct7 != 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OP_REG: begin
                regWrite = 1'b1;
                aluOp    = decodeAluOp(funct3, funct7[5]);
                // alternate encoding only for sub and sra
                illegal  = !((funct7 == 7'b0000000) ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: begin
                // includes fence and system
                illegal = 1'b1;
            end
        endcase
    end

    // eq/ne from the zero flag, the rest from the slt bit
    assign compare     = funct3[2] ? aluResult[0] : aluZero;
    assign branchTaken = isJal || (isBranch && (compare ^ funct3[0]));

    assign misaligned = isMem && (((size == SIZE_HALF) && aluResult[0]) ||
                                  ((size == SIZE_WORD) && (aluResult[1:0] != 2'b00)));
    assign except     = illegal || misaligned;

    assign ctrl.aluOp        = aluOp;
    assign ctrl.aluSrcImm    = srcImm;
    assign ctrl.aluSrcPc     = srcPc;
    assign ctrl.size         = size;
    assign ctrl.loadUnsigned = loadUnsigned;
    assign ctrl.wbSel        = wbSel;
    assign ctrl.except       = except;
    // excepting instruction just falls through to pc + 4
    assign ctrl.memWrite     = memWrite && !except;
    assign ctrl.regWrite     = regWrite && !except;
    assign ctrl.takeBranch   = branchTaken && !except;
    assign ctrl.jumpReg      = jumpReg && !except;

endmodule

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import rvPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     instruction,
    input  word_t     memOut,
    output word_t     pc,
    output word_t     memAddr,
    output word_t     memIn,
    output byteMask_t wrMask,
    output logic      memWr,
    output logic      except
);

    word_t pcPlus4;
    word_t pcPlusImm;
    word_t pcNext;
    word_t imm;
    word_t rs1Data;
    word_t rs2Data;
    word_t aluA;
    word_t aluB;
    word_t aluResult;
    logic  aluZero;
    word_t loadData;
    word_t writeBack;

    ctrlIf ctrl ();

    controller u_controller (
        .instruction (instruction),
        .aluZero     (aluZero),
        .aluResult   (aluResult),
        .ctrl        (ctrl)
    );

    immDecoder u_immDecoder (
        .instruction (instruction),
        .imm         (imm)
    );

    registerFile u_registerFile (
        .clk         (clk),
        .rs1         (instruction[19:15]),
        .rs2         (instruction[24:20]),
        .rd          (instruction[11:7]),
        .writeData   (writeBack),
        .writeEnable (ctrl.regWrite),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data)
    );

    alu u_alu (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    loadStoreUnit u_loadStoreUnit (
        .ctrl      (ctrl),
        .addr      (aluResult),
        .storeData (rs2Data),
        .memOut    (memOut),
        .memIn     (memIn),
        .loadData  (loadData),
        .wrMask    (wrMask)
    );

    assign pcPlus4   = pc + word_t'(4);
    assign pcPlusImm = pc + imm;

    // operand selects
    assign aluA = ctrl.aluSrcPc ? pc : rs1Data;
    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:  writeBack = loadData;
            WB_PC4:  writeBack = pcPlus4;
            WB_IMM:  writeBack = imm;
            default: writeBack = aluResult;
        endcase
    end

    // jalr target drops bit 0
    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = {aluResult[XLEN-1:1], 1'b0};
        end else if (ctrl.takeBranch) begin
            pcNext = pcPlusImm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign memAddr = aluResult;
    assign memWr   = ctrl.memWrite && !reset;
    assign except  = ctrl.except;

endmodule

`default_nettype wire

// File: cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpuAssertions import rvPkg::*; (
    input logic      clk,
    input logic      reset,
    input word_t     pc,
    input word_t     instruction,
    input word_t     memAddr,
    input byteMask_t wrMask,
    input logic      memWr,
    input logic      except
);

    int failures = 0;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       isFlow;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign isFlow = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);

    // first fetch right after reset
    assert property (@(posedge clk) $fell(reset) |-> pc == RESET_PC)
        else begin $error("pc is not the reset address after reset"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        !isFlow && !except |=> pc == $past(pc) + 32'd4)
        else begin $error("pc did not advance by 4"); failures++; end

    // byte lanes follow the low address bits
    assert property (@(posedge clk) disable iff (reset)
        memWr && funct3 == 3'b000 |-> wrMask == (4'b0001 << memAddr[1:0]))
        else begin $error("wrong byte store mask"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        memWr && funct3 == 3'b001 |-> wrMask == (4'b0011 << memAddr[1:0]))
        else begin $error("wrong halfword store mask"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        memWr && funct3 == 3'b010 |-> wrMask == 4'b1111)
        else begin $error("wrong word store mask"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        opcode == OP_JALR && !except |=> pc[0] == 1'b0)
        else begin $error("jalr target has bit 0 set"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        except |-> !memWr && wrMask == 4'b0000)
        else begin $error("memory write during an exception"); failures++; end

    assert property (@(posedge clk) disable iff (reset)
        except |=> pc == $past(pc) + 32'd4)
        else begin $error("pc did not fall through after an exception"); failures++; end

endmodule

`default_nettype wire

// File: cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import rvPkg::*; ();

    localparam word_t ALU_BASE    = 32'h100;
    localparam word_t BRANCH_BASE = 32'h140;
    localparam word_t STORE_BASE  = 32'h200;
    localparam word_t KNOWN_ADDR  = 32'h300;
    localparam word_t LOAD_BASE   = 32'h380;
    localparam word_t KNOWN_WORD  = 32'h80ff_7f81;
    localparam word_t MARKER      = 32'hc0de_0b17;
    localparam int    MAX_CYCLES  = 2000;

    logic      clk;
    logic      reset;
    word_t     instruction;
    word_t     memOut;
    word_t     pc;
    word_t     memAddr;
    word_t     memIn;
    byteMask_t wrMask;
    logic      memWr;
    logic      except;

    word_t rom [0:255];
    word_t dmem [0:255];
    word_t progPc;
    word_t endPc;
    word_t opA;
    word_t opB;
    int    aluSlot;
    int    branchSlot;
    int    loadSlot;
    int    passCount;
    int    failCount;
    bit    finished;

    string expName [$];
    word_t expAddr [$];
    word_t expVal [$];

    cpu u_dut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .memOut      (memOut),
        .pc          (pc),
        .memAddr     (memAddr),
        .memIn       (memIn),
        .wrMask      (wrMask),
        .memWr       (memWr),
        .except      (except)
    );

    bind cpu cpuAssertions u_assertions (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .instruction (instruction),
        .memAddr     (memAddr),
        .wrMask      (wrMask),
        .memWr       (memWr),
        .except      (except)
    );

    // both memories answer in the same cycle
    assign instruction = rom[pc[9:2]];
    assign memOut      = dmem[memAddr[9:2]];

    always #5 clk = ~clk;

    function automatic word_t fillWord(input logic [7:0] idx);
        return word_t'(32'h9e37_79b9 * ({24'd0, idx} + 32'd1));
    endfunction

    // logical shift with the vacated top bits filled from the sign
    function automatic word_t shiftRightArith(input word_t value, input logic [4:0] amount);
        word_t fill;
        fill = value[31] ? ~(32'hffff_ffff >> amount) : 32'd0;
        return (value >> amount) | fill;
    endfunction

    // differing signs decide on their own
    function automatic word_t lessSigned(input word_t x, input word_t y);
        logic less;
        if (x[31] != y[31]) begin
            less = x[31];
        end else begin
            less = x < y;
        end
        return {31'd0, less};
    endfunction

    // memory is refilled while reset is held
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] <= fillWord(i[7:0]);
            end
        end else if (memWr) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wrMask[lane]) begin
                    dmem[memAddr[9:2]][8*lane +: 8] <= memIn[8*lane +: 8];
                end
            end
        end
    end

    function automatic word_t rType(input logic [6:0] f7, input logic [2:0] f3,
                                    input regAddr_t rd, input regAddr_t rs1,
                                    input regAddr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t iType(input opcode_t op, input logic [2:0] f3,
                                    input regAddr_t rd, input regAddr_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t sType(input logic [2:0] f3, input regAddr_t rs1,
                                    input regAddr_t rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t bType(input logic [2:0] f3, input regAddr_t rs1,
                                    input regAddr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t uType(input opcode_t op, input regAddr_t rd,
                                    input logic [19:0] upper);
        return {upper, rd, op};
    endfunction

    function automatic word_t jType(input regAddr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input word_t insn);
        rom[progPc[9:2]] = insn;
        progPc = progPc + 32'd4;
    endtask

    // lui picks the rounded upper part, addi adds the signed low 12 bits
    task automatic loadConst(input regAddr_t rd, input word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;
        emit(uType(OP_LUI, rd, upper[19:0]));
        emit(iType(OP_IMM, 3'b000, rd, rd, value[11:0]));
    endtask

    task automatic expectWord(input string name, input word_t addr, input word_t value);
        expName.push_back(name);
        expAddr.push_back(addr);
        expVal.push_back(value);
    endtask

    // result lands in x5 and is stored to its own word
    task automatic aluCase(input string name, input word_t insn, input word_t expected);
        emit(insn);
        emit(sType(3'b010, 5'd10, 5'd5, 12'(aluSlot * 4)));
        expectWord(name, ALU_BASE + word_t'(aluSlot * 4), expected);
        aluSlot++;
    endtask

    task automatic loadCase(input string name, input logic [2:0] f3,
                            input logic [11:0] offset, input word_t expected);
        emit(iType(OP_LOAD, f3, 5'd5, 5'd13, offset));
        emit(sType(3'b010, 5'd14, 5'd5, 12'(loadSlot * 4)));
        expectWord(name, LOAD_BASE + word_t'(loadSlot * 4), expected);
        loadSlot++;
    endtask

    // a taken branch skips the marker store
    task automatic branchCase(input string name, input logic [2:0] f3,
                              input regAddr_t rs1, input regAddr_t rs2, input bit taken);
        word_t addr;
        addr = BRANCH_BASE + word_t'(branchSlot * 4);
        emit(bType(f3, rs1, rs2, 13'd8));
        emit(sType(3'b010, 5'd16, 5'd15, 12'(branchSlot * 4)));
        expectWord(name, addr, taken ? fillWord(addr[9:2]) : MARKER);
        branchSlot++;
    endtask

    task automatic buildProgram();
        word_t w;
        word_t addr;
        word_t here;
        logic [7:0]  kb;
        logic [15:0] kh;
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = 32'h0000_0013;
        end
        progPc = RESET_PC;
        loadConst(5'd1, opA);
        loadConst(5'd2, opB);
        loadConst(5'd10, ALU_BASE);
        loadConst(5'd11, STORE_BASE);
        loadConst(5'd13, KNOWN_ADDR);
        loadConst(5'd14, LOAD_BASE);
        loadConst(5'd15, MARKER);
        loadConst(5'd16, BRANCH_BASE);
        loadConst(5'd12, KNOWN_WORD);
        loadConst(5'd20, 32'd5);
        loadConst(5'd21, 32'hffff_fffd);
        loadConst(5'd22, 32'd5);

        aluCase("add", rType(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), opA + opB);
        aluCase("sub", rType(7'h20, 3'b000, 5'd5, 5'd1, 5'd2), opA - opB);
        aluCase("and", rType(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), opA & opB);
        aluCase("or", rType(7'h00, 3'b110, 5'd5, 5'd1, 5'd2), opA | opB);
        aluCase("xor", rType(7'h00, 3'b100, 5'd5, 5'd1, 5'd2), opA ^ opB);
        aluCase("sll", rType(7'h00, 3'b001, 5'd5, 5'd1, 5'd2), opA << opB[4:0]);
        aluCase("srl", rType(7'h00, 3'b101, 5'd5, 5'd1, 5'd2), opA >> opB[4:0]);
        aluCase("sra", rType(7'h20, 3'b101, 5'd5, 5'd1, 5'd2),
                shiftRightArith(opA, opB[4:0]));
        aluCase("slt", rType(7'h00, 3'b010, 5'd5, 5'd1, 5'd2), lessSigned(opA, opB));
        aluCase("sltu", rType(7'h00, 3'b011, 5'd5, 5'd1, 5'd2), (opA < opB) ? 32'd1 : 32'd0);
        aluCase("slli", iType(OP_IMM, 3'b001, 5'd5, 5'd1, 12'd7), opA << 7);
        aluCase("srai", iType(OP_IMM, 3'b101, 5'd5, 5'd1, {7'b0100000, 5'd13}),
                shiftRightArith(opA, 5'd13));
        aluCase("addi", iType(OP_IMM, 3'b000, 5'd5, 5'd1, 12'hb2e), opA - 32'd1234);
        here = progPc;
        aluCase("auipc", uType(OP_AUIPC, 5'd5, 20'h12345), here + 32'h1234_5000);

        for (int k = 0; k < 4; k++) begin
            addr = STORE_BASE + word_t'(5 * k);
            w = fillWord(addr[9:2]);
            w[8*k +: 8] = opA[7:0];
            emit(sType(3'b000, 5'd11, 5'd1, 12'(5 * k)));
            expectWord($sformatf("sb offset %0d", k), addr, w);
        end
        for (int j = 0; j < 2; j++) begin
            addr = STORE_BASE + 32'd16 + word_t'(6 * j);
            w = fillWord(addr[9:2]);
            w[16*j +: 16] = opA[15:0];
            emit(sType(3'b001, 5'd11, 5'd1, 12'(16 + 6 * j)));
            expectWord($sformatf("sh offset %0d", 2 * j), addr, w);
        end
        emit(sType(3'b010, 5'd11, 5'd1, 12'd24));
        expectWord("sw", STORE_BASE + 32'd24, opA);

        emit(sType(3'b010, 5'd13, 5'd12, 12'd0));
        for (int k = 0; k < 4; k++) begin
            kb = KNOWN_WORD[8*k +: 8];
            loadCase($sformatf("lb offset %0d", k), 3'b000, 12'(k), {{24{kb[7]}}, kb});
            loadCase($sformatf("lbu offset %0d", k), 3'b100, 12'(k), {24'd0, kb});
        end
        for (int j = 0; j < 2; j++) begin
            kh = KNOWN_WORD[16*j +: 16];
            loadCase($sformatf("lh offset %0d", 2 * j), 3'b001, 12'(2 * j), {{16{kh[15]}}, kh});
            loadCase($sformatf("lhu offset %0d", 2 * j), 3'b101, 12'(2 * j), {16'd0, kh});
        end
        loadCase("lw", 3'b010, 12'd0, KNOWN_WORD);

        // x20 = 5, x21 = -3, x22 = 5
        branchCase("beq taken", 3'b000, 5'd20, 5'd22, 1'b1);
        branchCase("beq not taken", 3'b000, 5'd20, 5'd21, 1'b0);
        branchCase("bne taken", 3'b001, 5'd20, 5'd21, 1'b1);
        branchCase("bne not taken", 3'b001, 5'd20, 5'd22, 1'b0);
        branchCase("blt taken", 3'b100, 5'd21, 5'd20, 1'b1);
        branchCase("blt not taken", 3'b100, 5'd20, 5'd21, 1'b0);
        branchCase("bge taken", 3'b101, 5'd20, 5'd21, 1'b1);
        branchCase("bge not taken", 3'b101, 5'd21, 5'd20, 1'b0);
        branchCase("bltu taken", 3'b110, 5'd20, 5'd21, 1'b1);
        branchCase("bltu not taken", 3'b110, 5'd21, 5'd20, 1'b0);
        branchCase("bgeu taken", 3'b111, 5'd21, 5'd20, 1'b1);
        branchCase("bgeu not taken", 3'b111, 5'd20, 5'd21, 1'b0);

        // skipped instructions would clobber the link register
        here = progPc;
        emit(jType(5'd6, 21'd8));
        emit(iType(OP_IMM, 3'b000, 5'd6, 5'd0, 12'd0));
        emit(sType(3'b010, 5'd16, 5'd6, 12'd48));
        expectWord("jal link", BRANCH_BASE + 32'd48, here + 32'd4);
        here = progPc;
        emit(uType(OP_AUIPC, 5'd7, 20'd0));
        emit(iType(OP_JALR, 3'b000, 5'd8, 5'd7, 12'd13));
        emit(iType(OP_IMM, 3'b000, 5'd8, 5'd0, 12'd0));
        emit(sType(3'b010, 5'd16, 5'd8, 12'd52));
        expectWord("jalr link", BRANCH_BASE + 32'd52, here + 32'd8);

        loadConst(5'd9, opA);
        emit({12'h7ff, 5'd0, 3'b000, 5'd9, 7'b0001011});
        emit(sType(3'b010, 5'd16, 5'd15, 12'd58));
        emit(iType(OP_FENCE, 3'b000, 5'd9, 5'd0, 12'd0));
        emit(sType(3'b010, 5'd16, 5'd9, 12'd60));
        addr = BRANCH_BASE + 32'd56;
        expectWord("misaligned sw", addr, fillWord(addr[9:2]));
        expectWord("illegal keeps rd", BRANCH_BASE + 32'd60, opA);

        endPc = progPc;
        emit(jType(5'd0, 21'd0));
    endtask

    task automatic waitForEnd(output bit done);
        done = 1'b0;
        for (int cycles = 0; cycles < MAX_CYCLES && !done; cycles++) begin
            @(negedge clk);
            if (pc == endPc) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic checkResults();
        word_t actual;
        foreach (expName[i]) begin
            actual = dmem[expAddr[i][9:2]];
            if (actual === expVal[i]) begin
                $display("PASS %s", expName[i]);
                passCount++;
            end else begin
                $display("MISMATCH %s expected %08h actual %08h", expName[i], expVal[i], actual);
                failCount++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        aluSlot    = 0;
        branchSlot = 0;
        loadSlot   = 0;
        passCount  = 0;
        failCount  = 0;
        void'($urandom(32'he553_d33c));
        opA        = $urandom();
        opB        = $urandom();
        buildProgram();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        waitForEnd(finished);
        if (!finished) begin
            $display("program did not reach its final instruction within %0d cycles",
                     MAX_CYCLES);
            $display("Test failed");
        end else begin
            checkResults();
            $display("%0d checks passed, %0d failed, %0d assertion failures",
                     passCount, failCount, u_dut.u_assertions.failures);
            if (failCount == 0 && u_dut.u_assertions.failures == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rvPkg.sv
ctrlIf.sv
alu.sv
immDecoder.sv
registerFile.sv
loadStoreUnit.sv
controller.sv
cpu.sv
cpu_assertions.sv
cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f compile.f

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/VcpuTb +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "Test passed"
